// File: Bender.yml
package:
  name: lcrc_link

export_include_dirs:
  - include

sources:
  - files:
      - hdl/lcrcTypesPkg.sv
      - hdl/linkCtlPkg.sv
      - hdl/crc32d16.sv
      - hdl/crc32d16N.sv
      - hdl/tlpLcrcTx.sv
      - hdl/tlpLcrcRx.sv
      - hdl/lcrcLink.sv
  - target: simulation
    files:
      - sim/lcrcLink_asserts.sv
      - sim/lcrcLinkTb.sv

// File: hdl/crc32d16.sv
// Seeded 16-bit parallel CRC-32
`timescale 1ns/1ps
`include "lcrc_macros.svh"

module crc32d16
   import lcrcTypesPkg::*;
#(
   parameter crcWordT Seed = `LCRC_SEED
) (
   input  logic     clk,
   input  logic     rstN,
   input  logic     load,   // Restart from Seed
   input  logic     en,     // Fold d into the register
   input  dataWordT d,
   output crcWordT  crc
);

   // ========================================
   // Next-state function
   // ========================================

   // Serial shift-and-XOR unrolled over one word
   // Bit 15 enters first, MSB of the register is the feedback tap
   function automatic crcWordT crcNext(input crcWordT crcIn, input dataWordT word);
      crcWordT acc;
      logic    fb;
      acc = crcIn;
      for (int i = 15; i >= 0; i--) begin
         fb  = acc[31] ^ word[i];
         acc = {acc[30:0], 1'b0};
         if (fb) begin
            acc = acc ^ `LCRC_POLY;
         end
      end
      return acc;
   endfunction

   // ========================================
   // CRC register
   // ========================================

   crcWordT crcQ;

   // Load wins over en so a new packet never inherits old state
   always_ff @(posedge clk) begin
      if (!rstN) begin
         crcQ <= Seed;
      end else if (load) begin
         crcQ <= Seed;
      end else if (en) begin
         crcQ <= crcNext(crcQ, d);
      end
   end

   // Result visible the cycle after the update edge
   assign crc = crcQ;

endmodule

// File: hdl/crc32d16N.sv
// LCRC as seen on the wire
`timescale 1ns/1ps
`include "lcrc_macros.svh"

module crc32d16N
   import lcrcTypesPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     load,
   input  logic     en,
   input  dataWordT d,       // Starts with the sequence word
   output crcWordT  crc32N   // Inverted and bit-reversed
);

   crcWordT crc;

   // Plain CRC register, all-ones start per PCI Express
   crc32d16 #(
      .Seed (`LCRC_SEED)
   ) crcCore (
      .clk  (clk),
      .rstN (rstN),
      .load (load),
      .en   (en),
      .d    (d),
      .crc  (crc)
   );

   // Complement each bit and mirror the order
   always_comb begin
      for (int i = 0; i < 32; i++) begin
         crc32N[i] = ~crc[31-i];
      end
   end

endmodule

// File: hdl/lcrcLink.sv
// LCRC link top level
`timescale 1ns/1ps

module lcrcLink
   import lcrcTypesPkg::*;
(
   input  logic     clk,
   input  logic     rstN,

   // Transmit side
   input  logic     txStart,
   input  logic     txValid,
   input  logic     txEnd,
   input  dataWordT txData,
   output logic     txIdle,
   output logic     linkValid,
   output logic     linkEnd,
   output dataWordT linkData,

   // Receive side
   input  logic     rxValid,
   input  logic     rxStart,
   input  logic     rxEnd,
   input  dataWordT rxData,
   output logic     rxGood,
   output logic     rxBad,
   output seqNumT   rxSeq
);

   // ========================================
   // Transmit path
   // ========================================

   // Sequence word in front, LCRC behind
   tlpLcrcTx txFramer (
      .clk       (clk),
      .rstN      (rstN),
      .txStart   (txStart),
      .txValid   (txValid),
      .txEnd     (txEnd),
      .txData    (txData),
      .txIdle    (txIdle),
      .linkValid (linkValid),
      .linkEnd   (linkEnd),
      .linkData  (linkData)
   );

   // ========================================
   // Receive path
   // ========================================

   // Independent of the transmit side, loopback is external
   tlpLcrcRx rxChecker (
      .clk     (clk),
      .rstN    (rstN),
      .rxValid (rxValid),
      .rxStart (rxStart),
      .rxEnd   (rxEnd),
      .rxData  (rxData),
      .rxGood  (rxGood),
      .rxBad   (rxBad),
      .rxSeq   (rxSeq)
   );

endmodule

// File: hdl/lcrcTypesPkg.sv
// LCRC datapath types
`include "lcrc_macros.svh"

package lcrcTypesPkg;

   // ========================================
   // Vector types with a meaning on the link
   // ========================================

   // One word of the 16-bit PHY datapath
   typedef logic [15:0] dataWordT;

   // Full CRC register or LCRC value
   typedef logic [31:0] crcWordT;

   // Data link layer sequence number
   // Wraps modulo 2**SEQ_WIDTH
   typedef logic [`SEQ_WIDTH-1:0] seqNumT;

endpackage

// File: hdl/linkCtlPkg.sv
// Link control state encodings
package linkCtlPkg;

   // ========================================
   // Transmit framer
   // ========================================

   // Names tell what is on linkData in that state
   typedef enum logic [2:0] {
      txIdleS,   // Waiting for txStart
      txSeqS,    // Sequence word on the link
      txDataS,   // Payload words, may have gaps
      txCrcHiS,  // Upper LCRC half
      txCrcLoS   // Lower LCRC half, with linkEnd
   } txStateT;

   // ========================================
   // Receive checker
   // ========================================

   typedef enum logic [1:0] {
      rxIdleS,   // No packet open
      rxDataS,   // Collecting words up to rxEnd
      rxCheckS   // Compare and report
   } rxStateT;

endpackage

// File: hdl/tlpLcrcRx.sv
// TLP LCRC checker
`timescale 1ns/1ps
`include "lcrc_macros.svh"

module tlpLcrcRx
   import lcrcTypesPkg::*, linkCtlPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     rxValid,
   input  logic     rxStart,   // Sequence word
   input  logic     rxEnd,     // Low LCRC word
   input  dataWordT rxData,
   output logic     rxGood,    // One-cycle pulses
   output logic     rxBad,
   output seqNumT   rxSeq      // Valid with either pulse
);

   // ========================================
   // Word qualifiers
   // ========================================

   rxStateT  stateQ;
   rxStateT  stateD;
   dataWordT hold0Q;   // Newest word
   dataWordT hold1Q;   // Word before that
   logic     fullQ;    // Both holding slots filled
   logic     startIn;
   logic     wordIn;
   logic     crcMatch;
   crcWordT  crc32N;

   // A start word always opens a packet, even mid-packet
   assign startIn = rxValid && rxStart;
   assign wordIn  = rxValid && !rxStart && stateQ == rxDataS;

   // Next state
   always_comb begin
      stateD = stateQ;
      if (startIn) begin
         stateD = rxDataS;
      end else begin
         case (stateQ)
            rxDataS:  if (rxValid && rxEnd) stateD = rxCheckS;
            rxCheckS: stateD = rxIdleS;
            default:  stateD = stateQ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         stateQ <= rxIdleS;
         fullQ  <= 1'b0;
         rxSeq  <= '0;
      end else begin
         stateQ <= stateD;
         if (startIn) begin
            fullQ <= 1'b0;
            rxSeq <= rxData[`SEQ_WIDTH-1:0];
         end else if (wordIn) begin
            fullQ <= 1'b1;
         end
      end
   end

   // ========================================
   // Two-word delay line
   // ========================================

   // The two newest words are never hashed
   // At rxEnd they are exactly the LCRC pair
   always_ff @(posedge clk) begin
      if (startIn || wordIn) begin
         hold0Q <= rxData;
         hold1Q <= hold0Q;
      end
   end

   // Oldest held word enters the CRC when a new one arrives
   crc32d16N lcrcChk (
      .clk    (clk),
      .rstN   (rstN),
      .load   (startIn),
      .en     (wordIn && fullQ),
      .d      (hold1Q),
      .crc32N (crc32N)
   );

   // ========================================
   // Result
   // ========================================

   // High half arrived first so it sits in hold1Q
   assign crcMatch = crc32N == {hold1Q, hold0Q};

   assign rxGood = stateQ == rxCheckS && crcMatch;
   assign rxBad  = stateQ == rxCheckS && !crcMatch;

endmodule

// File: hdl/tlpLcrcTx.sv
// TLP sequence and LCRC framer
`timescale 1ns/1ps

module tlpLcrcTx
   import lcrcTypesPkg::*, linkCtlPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     txStart,   // One-cycle packet open
   input  logic     txValid,   // Payload word on txData
   input  logic     txEnd,     // With the last payload word
   input  dataWordT txData,
   output logic     txIdle,    // Source may start a packet
   output logic     linkValid,
   output logic     linkEnd,   // Low LCRC word
   output dataWordT linkData
);

   // ========================================
   // Registers
   // ========================================

   txStateT  stateQ;
   txStateT  stateD;
   seqNumT   seqQ;     // Number for the next packet
   dataWordT dataQ;    // Sequence or payload word on the link
   logic     validQ;   // dataQ holds a word to send
   logic     lastQ;    // dataQ is the final payload word
   logic     wordOut;  // Link carries a CRC-covered word
   crcWordT  crc32N;

   // Next state
   always_comb begin
      stateD = stateQ;
      case (stateQ)
         txIdleS:  if (txStart) stateD = txSeqS;
         txSeqS:   stateD = txDataS;
         // Leave once the last payload word is on the link
         txDataS:  if (validQ && lastQ) stateD = txCrcHiS;
         txCrcHiS: stateD = txCrcLoS;
         txCrcLoS: stateD = txIdleS;
         default:  stateD = txIdleS;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         stateQ <= txIdleS;
         seqQ   <= '0;
         validQ <= 1'b0;
         lastQ  <= 1'b0;
      end else begin
         stateQ <= stateD;
         case (stateQ)
            txIdleS: begin
               if (txStart) begin
                  validQ <= 1'b1;
                  lastQ  <= 1'b0;
               end
            end
            // Payload accepted here shows up one cycle later
            txSeqS, txDataS: begin
               validQ <= txValid;
               lastQ  <= txValid && txEnd;
            end
            // Packet done, 12-bit counter wraps on its own
            txCrcLoS: seqQ <= seqQ + 1'b1;
            default: ;
         endcase
      end
   end

   // Link word register
   always_ff @(posedge clk) begin
      if (stateQ == txIdleS && txStart) begin
         dataQ <= dataWordT'(seqQ);   // Zero bits above the number
      end else if ((stateQ == txSeqS || stateQ == txDataS) && txValid) begin
         dataQ <= txData;
      end
   end

   // ========================================
   // Link outputs
   // ========================================

   assign wordOut   = (stateQ == txSeqS) || (stateQ == txDataS && validQ);
   assign linkValid = wordOut || stateQ == txCrcHiS || stateQ == txCrcLoS;
   assign linkEnd   = stateQ == txCrcLoS;
   assign txIdle    = stateQ == txIdleS;

   // CRC halves straight from the core, which holds once en drops
   always_comb begin
      case (stateQ)
         txCrcHiS: linkData = crc32N[31:16];
         txCrcLoS: linkData = crc32N[15:0];
         default:  linkData = dataQ;
      endcase
   end

   // Every emitted word goes into the CRC in the same cycle
   crc32d16N lcrcGen (
      .clk    (clk),
      .rstN   (rstN),
      .load   (stateQ == txIdleS && txStart),
      .en     (wordOut),
      .d      (dataQ),
      .crc32N (crc32N)
   );

endmodule

// File: include/lcrc_macros.svh
// LCRC shared constants
`ifndef LCRC_MACROS_SVH
`define LCRC_MACROS_SVH

// ========================================
// CRC-32 parameters
// ========================================

// Generator polynomial, x^32 term implied
`define LCRC_POLY 32'h04C1_1DB7

// Register value at the start of every TLP
`define LCRC_SEED 32'hFFFF_FFFF

// ========================================
// Data link layer framing
// ========================================

// Sequence number carried ahead of the TLP
// Upper bits of the sequence word stay zero on the link
`define SEQ_WIDTH 12

`endif

// File: sim/lcrcLinkTb.sv
// LCRC link directed testbench
`timescale 1ns/1ps
`include "lcrc_macros.svh"

module lcrcLinkTb
   import lcrcTypesPkg::*;
();

   logic     clk = 1'b0;
   logic     rstN;
   logic     txStart;
   logic     txValid;
   logic     txEnd;
   dataWordT txData;
   logic     txIdle;
   logic     linkValid;
   logic     linkEnd;
   dataWordT linkData;
   logic     rxValid;
   logic     rxStart;
   logic     rxEnd;
   dataWordT rxData;
   logic     rxGood;
   logic     rxBad;
   seqNumT   rxSeq;

   integer   seed = 32'h119d_14f3;
   int       errors;
   int       checks;
   bit       abortRun;     // Set on a timeout, later packets are skipped
   string    testName;
   int       expSeq;       // Sequence number the framer should send next
   int       flipWord;     // Link word index to corrupt, -1 for none
   dataWordT flipMask;
   bit       inPkt;
   int       wordIdx;
   bit       endPending;
   dataWordT curPkt[$];
   dataWordT lastPkt[$];   // Words of the last complete link packet
   dataWordT expStream[$]; // Sequence word followed by the payload

   always #50 clk = ~clk;

   lcrcLink lcrcLink_i (.*);

   // ========================================
   // Loopback and link capture
   // ========================================

   // Link outputs are stable at the falling edge, so rx inputs follow them here
   always @(negedge clk) begin
      // Result pulse belongs to the cycle right after rxEnd
      if (endPending && !(rxGood || rxBad)) begin
         errors++;
         $display("No rxGood or rxBad pulse in the cycle after rxEnd in %s", testName);
      end
      rxValid = linkValid;
      rxStart = linkValid && !inPkt;
      rxEnd   = linkEnd;
      rxData  = linkData;
      endPending = rxValid && rxEnd;
      if (linkValid) begin
         if (!inPkt) begin
            wordIdx = 0;
            curPkt.delete();
         end
         if (wordIdx == flipWord) begin
            rxData = linkData ^ flipMask;
         end
         curPkt.push_back(linkData);
         wordIdx++;
         inPkt = !linkEnd;
         if (linkEnd) begin
            lastPkt = curPkt;
         end
      end
   end

   // ========================================
   // Reference model and helpers
   // ========================================

   // Bit-serial CRC over expStream, MSB of each word first, then wire order
   function automatic crcWordT refLcrc();
      crcWordT crcVal;
      crcWordT wireVal;
      logic    fb;
      crcVal = `LCRC_SEED;
      foreach (expStream[w]) begin
         for (int b = 15; b >= 0; b--) begin
            fb     = crcVal[31] ^ expStream[w][b];
            crcVal = {crcVal[30:0], 1'b0} ^ (fb ? `LCRC_POLY : 32'h0);
         end
      end
      for (int i = 0; i < 32; i++) begin
         wireVal[i] = ~crcVal[31 - i];
      end
      return wireVal;
   endfunction

   task automatic checkVal(input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal);
      checks++;
      if (expVal !== actVal) begin
         errors++;
         $display("Error in %s, %s: expected %h, actual %h", testName, what, expVal, actVal);
      end
   endtask

   task automatic waitIdle();
      int n;
      n = 0;
      while (!txIdle && !abortRun) begin
         @(negedge clk);
         n++;
         if (n > 50) begin
            errors++;
            abortRun = 1'b1;
            $display("Timed out waiting for txIdle in %s", testName);
         end
      end
   endtask

   // Sends one packet, waits for the receive verdict and checks both sides
   task automatic runPacket(input int len, input int gapMax, input int flipIdx,
                            input int flipBit, input logic expGood);
      crcWordT expCrc;
      logic    gotGood;
      logic    gotBad;
      seqNumT  gotSeq;
      int      n;
      int      gap;
      waitIdle();
      if (abortRun) return;
      expStream.delete();
      expStream.push_back(dataWordT'(expSeq));
      for (int i = 0; i < len; i++) begin
         expStream.push_back(dataWordT'($random(seed)));
      end
      flipWord = flipIdx;
      flipMask = dataWordT'(1) << flipBit;
      txStart = 1'b1;
      for (int i = 1; i <= len; i++) begin
         @(negedge clk);
         txStart = 1'b0;
         gap = (i > 1 && gapMax > 0) ? $unsigned($random(seed)) % (gapMax + 1) : 0;
         repeat (gap) begin
            txValid = 1'b0;
            txEnd   = 1'b0;
            @(negedge clk);
         end
         txValid = 1'b1;
         txData  = expStream[i];
         txEnd   = (i == len);
      end
      @(negedge clk);
      txValid = 1'b0;
      txEnd   = 1'b0;
      n = 0;
      while (!(rxGood || rxBad) && !abortRun) begin
         @(negedge clk);
         n++;
         if (n > 20) begin
            errors++;
            abortRun = 1'b1;
            $display("Timed out waiting for the receive result in %s", testName);
         end
      end
      if (abortRun) return;
      gotGood  = rxGood;
      gotBad   = rxBad;
      gotSeq   = rxSeq;
      flipWord = -1;
      expCrc   = refLcrc();
      checkVal("link word count", len + 3, lastPkt.size());
      if (lastPkt.size() == len + 3) begin
         for (int i = 0; i <= len; i++) begin
            checkVal("link word", expStream[i], lastPkt[i]);
         end
         checkVal("LCRC high", expCrc[31:16], lastPkt[len + 1]);
         checkVal("LCRC low", expCrc[15:0], lastPkt[len + 2]);
      end
      checkVal("rxGood", expGood, gotGood);
      checkVal("rxBad", !expGood, gotBad);
      checkVal("rxSeq", expSeq, gotSeq);
      expSeq = (expSeq + 1) % (1 << `SEQ_WIDTH);
   endtask

   // ========================================
   // Tests
   // ========================================

   task automatic testSeqWord();
      testName = "sequence word";
      runPacket(1, 0, -1, 0, 1'b1);
      if (lastPkt.size() > 0) begin
         checkVal("sequence word after reset", 16'h0000, lastPkt[0]);
      end
   endtask

   task automatic testRandomPayloads();
      testName = "random payloads";
      repeat (24) begin
         runPacket(1 + $unsigned($random(seed)) % 32, 0, -1, 0, 1'b1);
      end
   endtask

   // Payload, high LCRC and low LCRC corruption in turn
   task automatic testCorruption();
      int len;
      int idx;
      testName = "corruption";
      for (int k = 0; k < 6; k++) begin
         len = 1 + $unsigned($random(seed)) % 16;
         case (k % 3)
            0:       idx = 1 + $unsigned($random(seed)) % len;
            1:       idx = len + 1;
            default: idx = len + 2;
         endcase
         runPacket(len, 0, idx, $unsigned($random(seed)) % 16, 1'b0);
      end
      // Clean packet after the bad ones
      runPacket(4, 0, -1, 0, 1'b1);
   endtask

   task automatic testGaps();
      testName = "txValid gaps";
      repeat (8) begin
         runPacket(2 + $unsigned($random(seed)) % 31, 3, -1, 0, 1'b1);
      end
   endtask

   // Minimal packets until the counter is back at zero
   task automatic testWrap();
      int n;
      testName = "sequence wrap";
      n = (1 << `SEQ_WIDTH) - expSeq;
      for (int i = 0; i < n && !abortRun; i++) begin
         runPacket(1, 0, -1, 0, 1'b1);
      end
      runPacket(1, 0, -1, 0, 1'b1);
      if (lastPkt.size() > 0) begin
         checkVal("sequence word after wrap", 16'h0000, lastPkt[0]);
      end
   endtask

   initial begin
      errors     = 0;
      checks     = 0;
      abortRun   = 1'b0;
      expSeq     = 0;
      flipWord   = -1;
      flipMask   = '0;
      inPkt      = 1'b0;
      wordIdx    = 0;
      endPending = 1'b0;
      rstN       = 1'b0;
      txStart    = 1'b0;
      txValid    = 1'b0;
      txEnd      = 1'b0;
      txData     = '0;
      rxValid    = 1'b0;
      rxStart    = 1'b0;
      rxEnd      = 1'b0;
      rxData     = '0;
      repeat (4) @(negedge clk);
      testName = "reset";
      checkVal("linkValid", 0, linkValid);
      checkVal("linkEnd", 0, linkEnd);
      checkVal("rxGood", 0, rxGood);
      checkVal("rxBad", 0, rxBad);
      checkVal("txIdle", 1, txIdle);
      rstN = 1'b1;
      testSeqWord();
      testRandomPayloads();
      testCorruption();
      testGaps();
      testWrap();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: sim/lcrcLink_asserts.sv
// LCRC link protocol assertions
`timescale 1ns/1ps

module lcrcLinkAsserts (
   input logic clk,
   input logic rstN,
   input logic txIdle,
   input logic linkValid,
   input logic linkEnd,
   input logic rxGood,
   input logic rxBad
);

   // ========================================
   // Receive verdict
   // ========================================

   // One verdict per packet
   assert property (@(posedge clk) disable iff (!rstN) !(rxGood && rxBad))
      else $error("rxGood and rxBad high in the same cycle");

   // ========================================
   // Transmit link
   // ========================================

   // linkEnd marks the low LCRC word, which is always a valid word
   assert property (@(posedge clk) disable iff (!rstN) linkEnd |-> linkValid)
      else $error("linkEnd without linkValid");

   // Framer busy for the whole packet
   assert property (@(posedge clk) disable iff (!rstN) linkValid |-> !txIdle)
      else $error("txIdle high while linkValid is high");

endmodule

bind lcrcLink lcrcLinkAsserts linkChecks (
   .clk       (clk),
   .rstN      (rstN),
   .txIdle    (txIdle),
   .linkValid (linkValid),
   .linkEnd   (linkEnd),
   .rxGood    (rxGood),
   .rxBad     (rxBad)
);

// File: tb.f
+incdir+include
hdl/lcrcTypesPkg.sv
hdl/linkCtlPkg.sv
hdl/crc32d16.sv
hdl/crc32d16N.sv
hdl/tlpLcrcTx.sv
hdl/tlpLcrcRx.sv
hdl/lcrcLink.sv
sim/lcrcLink_asserts.sv
sim/lcrcLinkTb.sv
